//--- design/fu_pkg.sv
package fu_pkg;

    // ======================================================================
    // datapath widths
    // ======================================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // pc step between sequential instructions
    localparam int INSN_BYTES = 4;
    localparam int BYTE_LANES = XLEN / 8;

    // ======================================================================
    // opcodes and kinds
    // ======================================================================
    typedef enum logic [3:0] {
        op_add, op_sub, op_slt, op_sltu, op_and, op_nor, op_or, op_xor,
        op_sll, op_srl, op_sra, op_lui, op_mul, op_eq, op_ne
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_b, br_bl, br_jirl, br_cond
    } br_kind_e;

    typedef enum logic [1:0] {
        mem_none, mem_load_word, mem_store_word, mem_store_byte
    } mem_op_e;

    // ======================================================================
    // records between stages and on the ports
    // ======================================================================
    typedef struct packed {
        alu_op_e                op;
        logic [XLEN-1:0]        src1;
        logic [XLEN-1:0]        src2;
        logic [XLEN-1:0]        store_data;
        logic [XLEN-1:0]        pc;
        br_kind_e               br_kind;
        logic                   pred_taken;
        logic [XLEN-1:0]        br_offset;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   gr_we;
        mem_op_e                mem_op;
    } fu_req_t;

    typedef struct packed {
        logic                   valid;
        // alu result, also the memory address
        logic [XLEN-1:0]        result;
        logic [XLEN-1:0]        store_data;
        logic [BYTE_LANES-1:0]  sel_n;
        mem_op_e                mem_op;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   gr_we;
    } ex_mem_t;

    typedef struct packed {
        logic                   mispredict;
        logic [XLEN-1:0]        target;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        logic [REG_ADDR_W-1:0]  dest;
        logic [XLEN-1:0]        data;
    } wb_t;

    typedef struct packed {
        logic                   ce;
        logic                   we_n;
        logic [BYTE_LANES-1:0]  sel_n;
        logic [XLEN-1:0]        addr;
        logic [XLEN-1:0]        wdata;
    } mem_req_t;

endpackage

//--- design/fu_alu.sv
`timescale 1ns/1ns

module fu_alu (
    input  fu_pkg::alu_op_e         op_i,
    input  logic [fu_pkg::XLEN-1:0] src1_i,
    input  logic [fu_pkg::XLEN-1:0] src2_i,
    output logic [fu_pkg::XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       slt_cond;
    logic       sltu_cond;

    // shifts use only the low five bits
    assign shamt     = src2_i[4:0];
    assign slt_cond  = $signed(src1_i) < $signed(src2_i);
    assign sltu_cond = src1_i < src2_i;

    always_comb begin
        case (op_i)
            fu_pkg::op_add:  result_o = src1_i + src2_i;
            fu_pkg::op_sub:  result_o = src1_i - src2_i;
            fu_pkg::op_slt:  result_o = {{(fu_pkg::XLEN-1){1'b0}}, slt_cond};
            fu_pkg::op_sltu: result_o = {{(fu_pkg::XLEN-1){1'b0}}, sltu_cond};
            fu_pkg::op_and:  result_o = src1_i & src2_i;
            fu_pkg::op_nor:  result_o = ~(src1_i | src2_i);
            fu_pkg::op_or:   result_o = src1_i | src2_i;
            fu_pkg::op_xor:  result_o = src1_i ^ src2_i;
            fu_pkg::op_sll:  result_o = src1_i << shamt;
            fu_pkg::op_srl:  result_o = src1_i >> shamt;
            fu_pkg::op_sra:  result_o = $signed(src1_i) >>> shamt;
            // upper immediate sits above twelve zero bits
            fu_pkg::op_lui:  result_o = {src2_i[19:0], 12'b0};
            // low word of the product only
            fu_pkg::op_mul:  result_o = src1_i * src2_i;
            fu_pkg::op_eq: begin
                result_o = {{(fu_pkg::XLEN-1){1'b0}}, src1_i == src2_i};
            end
            fu_pkg::op_ne: begin
                result_o = {{(fu_pkg::XLEN-1){1'b0}}, src1_i != src2_i};
            end
            default:         result_o = '0;
        endcase
    end

endmodule

//--- design/fu_branch_unit.sv
`timescale 1ns/1ns

module fu_branch_unit (
    input  logic [fu_pkg::XLEN-1:0] pc_i,
    input  fu_pkg::br_kind_e        kind_i,
    input  fu_pkg::alu_op_e         op_i,
    input  logic [fu_pkg::XLEN-1:0] src1_i,
    input  logic [fu_pkg::XLEN-1:0] src2_i,
    input  logic [fu_pkg::XLEN-1:0] offset_i,
    input  logic                    pred_taken_i,
    output fu_pkg::redirect_t       redirect_o
);

    logic                    actual_taken;
    logic [fu_pkg::XLEN-1:0] actual_target;
    logic [fu_pkg::XLEN-1:0] pc_next;
    logic                    cond_met;

    assign pc_next  = pc_i + fu_pkg::XLEN'(fu_pkg::INSN_BYTES);
    assign cond_met = ((op_i == fu_pkg::op_eq) && (src1_i == src2_i)) ||
                      ((op_i == fu_pkg::op_ne) && (src1_i != src2_i));

    // actual outcome
    always_comb begin
        actual_taken  = 1'b0;
        actual_target = pc_i + offset_i;
        case (kind_i)
            fu_pkg::br_b, fu_pkg::br_bl: begin
                actual_taken = 1'b1;
            end
            fu_pkg::br_jirl: begin
                actual_taken  = 1'b1;
                actual_target = src1_i + offset_i;
            end
            fu_pkg::br_cond: begin
                actual_taken = cond_met;
            end
            default: begin
                actual_taken = 1'b0;
            end
        endcase
    end

    // compare against the front end's guess
    always_comb begin
        if (actual_taken != pred_taken_i) begin
            redirect_o.mispredict = 1'b1;
            redirect_o.target     = actual_taken ? actual_target : pc_next;
        end else begin
            redirect_o.mispredict = 1'b0;
            redirect_o.target     = '0;
        end
    end

endmodule

//--- design/fu_issue_stage.sv
`timescale 1ns/1ns

module fu_issue_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_i,
    input  fu_pkg::fu_req_t req_i,
    input  logic            stall_i,
    output logic            ready_o,
    output logic            ex_valid_o,
    output fu_pkg::fu_req_t ex_req_o
);

    logic            valid_q;
    fu_pkg::fu_req_t req_q;

    // ======================================================================
    // handshake
    // ======================================================================
    // only the memory stage can hold the pipe
    assign ready_o = !stall_i;

    // ======================================================================
    // issue-to-execute register
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            // an idle cycle leaves a bubble behind
            valid_q <= valid_i;
        end
    end

    // payload only moves with an accepted instruction
    always_ff @(posedge clk) begin
        if (!stall_i && valid_i) begin
            req_q <= req_i;
        end
    end

    assign ex_valid_o = valid_q;
    assign ex_req_o   = req_q;

endmodule

//--- design/fu_ex_stage.sv
`timescale 1ns/1ns

module fu_ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid_i,
    input  fu_pkg::fu_req_t   ex_req_i,
    input  logic              stall_i,
    output fu_pkg::ex_mem_t   ex_mem_o,
    output fu_pkg::redirect_t redirect_o
);

    logic [fu_pkg::XLEN-1:0]       alu_result;
    logic [fu_pkg::XLEN-1:0]       link_addr;
    logic [fu_pkg::XLEN-1:0]       result;
    logic                          is_link;
    logic [fu_pkg::BYTE_LANES-1:0] sel_n;
    fu_pkg::redirect_t             br_redirect;

    logic                          valid_q;
    logic [fu_pkg::XLEN-1:0]       result_q;
    logic [fu_pkg::XLEN-1:0]       store_data_q;
    logic [fu_pkg::BYTE_LANES-1:0] sel_n_q;
    fu_pkg::mem_op_e               mem_op_q;
    logic [fu_pkg::REG_ADDR_W-1:0] dest_q;
    logic                          gr_we_q;
    fu_pkg::redirect_t             redirect_q;

    // ======================================================================
    // execute logic
    // ======================================================================
    fu_alu u_alu (
        .op_i     (ex_req_i.op),
        .src1_i   (ex_req_i.src1),
        .src2_i   (ex_req_i.src2),
        .result_o (alu_result)
    );

    fu_branch_unit u_branch_unit (
        .pc_i         (ex_req_i.pc),
        .kind_i       (ex_req_i.br_kind),
        .op_i         (ex_req_i.op),
        .src1_i       (ex_req_i.src1),
        .src2_i       (ex_req_i.src2),
        .offset_i     (ex_req_i.br_offset),
        .pred_taken_i (ex_req_i.pred_taken),
        .redirect_o   (br_redirect)
    );

    // bl and jirl both write the return address
    assign is_link   = (ex_req_i.br_kind == fu_pkg::br_bl) ||
                       (ex_req_i.br_kind == fu_pkg::br_jirl);
    assign link_addr = ex_req_i.pc + fu_pkg::XLEN'(fu_pkg::INSN_BYTES);
    assign result    = is_link ? link_addr : alu_result;

    // active-low byte lanes, address taken from the alu
    always_comb begin
        case (ex_req_i.mem_op)
            fu_pkg::mem_store_byte: begin
                sel_n = ~(fu_pkg::BYTE_LANES'(1) << alu_result[1:0]);
            end
            fu_pkg::mem_load_word, fu_pkg::mem_store_word: sel_n = '0;
            default:                                        sel_n = '1;
        endcase
    end

    // ======================================================================
    // execute-to-memory register
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= 1'b0;
            redirect_q <= '0;
        end else if (!stall_i) begin
            valid_q    <= ex_valid_i;
            redirect_q <= ex_valid_i ? br_redirect : '0;
        end else begin
            // held instruction has not resolved yet, so no redirect this cycle
            redirect_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_q     <= result;
            store_data_q <= ex_req_i.store_data;
            sel_n_q      <= sel_n;
            mem_op_q     <= ex_req_i.mem_op;
            dest_q       <= ex_req_i.dest;
            gr_we_q      <= ex_req_i.gr_we;
        end
    end

    assign ex_mem_o.valid      = valid_q;
    assign ex_mem_o.result     = result_q;
    assign ex_mem_o.store_data = store_data_q;
    assign ex_mem_o.sel_n      = sel_n_q;
    assign ex_mem_o.mem_op     = mem_op_q;
    assign ex_mem_o.dest       = dest_q;
    assign ex_mem_o.gr_we      = gr_we_q;
    assign redirect_o          = redirect_q;

endmodule

//--- design/fu_mem_stage.sv
`timescale 1ns/1ns

module fu_mem_stage #(
    parameter int MEM_WAIT_CYCLES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  fu_pkg::ex_mem_t         ex_mem_i,
    output logic                    mem_busy_o,
    output fu_pkg::mem_req_t        mem_req_o,
    input  logic [fu_pkg::XLEN-1:0] mem_rdata_i,
    output logic                    mem_ready_o,
    output fu_pkg::wb_t             wb_o
);

    localparam int CNT_W = $clog2(MEM_WAIT_CYCLES + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done
    } mem_state_e;

    mem_state_e                    state_q;
    mem_state_e                    state_d;
    logic [CNT_W-1:0]              cnt_q;
    logic [CNT_W-1:0]              cnt_d;

    logic                          is_mem;
    logic                          is_store;
    logic                          is_load;
    logic                          wb_valid_d;
    logic [fu_pkg::XLEN-1:0]       wb_data_d;

    logic                          wb_valid_q;
    logic [fu_pkg::REG_ADDR_W-1:0] wb_dest_q;
    logic [fu_pkg::XLEN-1:0]       wb_data_q;

    assign is_mem   = ex_mem_i.valid && (ex_mem_i.mem_op != fu_pkg::mem_none);
    assign is_store = is_mem && ((ex_mem_i.mem_op == fu_pkg::mem_store_word) ||
                                 (ex_mem_i.mem_op == fu_pkg::mem_store_byte));
    assign is_load  = is_mem && (ex_mem_i.mem_op == fu_pkg::mem_load_word);

    // ======================================================================
    // wait machine
    // ======================================================================
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            st_idle: begin
                if (is_mem) begin
                    state_d = st_wait;
                    cnt_d   = CNT_W'(1);
                end
            end
            st_wait: begin
                if (cnt_q == CNT_W'(MEM_WAIT_CYCLES)) begin
                    state_d = st_done;
                end else begin
                    cnt_d = cnt_q + CNT_W'(1);
                end
            end
            st_done: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // busy from the first cycle of an access until the done cycle
    assign mem_busy_o  = (state_q == st_wait) || ((state_q == st_idle) && is_mem);
    assign mem_ready_o = (state_q == st_done);

    // ======================================================================
    // memory port
    // ======================================================================
    always_comb begin
        mem_req_o.ce    = is_mem;
        mem_req_o.we_n  = !is_store;
        mem_req_o.sel_n = is_mem ? ex_mem_i.sel_n : '1;
        mem_req_o.addr  = ex_mem_i.result;
        if (!is_store) begin
            mem_req_o.wdata = '0;
        end else if (ex_mem_i.mem_op == fu_pkg::mem_store_byte) begin
            // byte copied onto every lane
            // sel_n picks the one written
            mem_req_o.wdata = {fu_pkg::BYTE_LANES{ex_mem_i.store_data[7:0]}};
        end else begin
            mem_req_o.wdata = ex_mem_i.store_data;
        end
    end

    // ======================================================================
    // writeback register
    // ======================================================================
    assign wb_valid_d = ex_mem_i.valid && ex_mem_i.gr_we && !is_store && !mem_busy_o;
    assign wb_data_d  = is_load ? mem_rdata_i : ex_mem_i.result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= wb_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest_q <= ex_mem_i.dest;
        wb_data_q <= wb_data_d;
    end

    assign wb_o.valid = wb_valid_q;
    assign wb_o.dest  = wb_dest_q;
    assign wb_o.data  = wb_data_q;

endmodule

//--- design/fu_top.sv
`timescale 1ns/1ns

module fu_top #(
    parameter int MEM_WAIT_CYCLES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  fu_pkg::fu_req_t         req_i,
    output logic                    ready_o,
    output fu_pkg::redirect_t       redirect_o,
    output fu_pkg::mem_req_t        mem_req_o,
    input  logic [fu_pkg::XLEN-1:0] mem_rdata_i,
    output logic                    mem_ready_o,
    output fu_pkg::wb_t             wb_o
);

    // stall raised by the memory stage, fanned out to the earlier stages
    logic            mem_busy;
    logic            ex_valid;
    fu_pkg::fu_req_t ex_req;
    fu_pkg::ex_mem_t ex_mem;

    // ======================================================================
    // issue
    // ======================================================================
    fu_issue_stage u_issue_stage (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .stall_i    (mem_busy),
        .ready_o    (ready_o),
        .ex_valid_o (ex_valid),
        .ex_req_o   (ex_req)
    );

    // ======================================================================
    // execute
    // ======================================================================
    fu_ex_stage u_ex_stage (
        .clk        (clk),
        .rst        (rst),
        .ex_valid_i (ex_valid),
        .ex_req_i   (ex_req),
        .stall_i    (mem_busy),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect_o)
    );

    // ======================================================================
    // memory and writeback
    // ======================================================================
    fu_mem_stage #(
        .MEM_WAIT_CYCLES (MEM_WAIT_CYCLES)
    ) u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .ex_mem_i    (ex_mem),
        .mem_busy_o  (mem_busy),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_o (mem_ready_o),
        .wb_o        (wb_o)
    );

endmodule

//--- sim/fu_tb.sv
`timescale 1ns/1ns

module fu_tb;

    localparam int MEM_WAIT_CYCLES = 4;
    localparam int NUM_INSNS       = 400;
    localparam int TIMEOUT_NS      = NUM_INSNS * (MEM_WAIT_CYCLES + 6) * 4 + 2000;
    localparam int MEM_WORDS       = 16;
    localparam logic [31:0] MEM_BASE = 32'h100;

    logic                  clk;
    logic                  rst;
    logic                  valid_i;
    fu_pkg::fu_req_t       req_i;
    logic                  ready_o;
    fu_pkg::redirect_t     redirect_o;
    fu_pkg::mem_req_t      mem_req_o;
    logic [31:0]           mem_rdata_i;
    logic                  mem_ready_o;
    fu_pkg::wb_t           wb_o;

    integer                seed = 32'hacb5;
    int                    errors = 0;
    int                    tests_failed = 0;
    int                    accepted = 0;
    int                    wb_seen = 0;
    int                    stores_done = 0;
    logic [31:0]           mem [MEM_WORDS];
    logic [31:0]           shadow [MEM_WORDS];
    fu_pkg::wb_t           wb_q [$];
    logic [31:0]           redirect_q [$];
    fu_pkg::fu_req_t       next_req;

    fu_top #(.MEM_WAIT_CYCLES(MEM_WAIT_CYCLES)) u_fu_top (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .req_i       (req_i),
        .ready_o     (ready_o),
        .redirect_o  (redirect_o),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_o (mem_ready_o),
        .wb_o        (wb_o)
    );

    always #2 clk = ~clk;

    // read data is always on the bus
    // the stage samples it in the done cycle
    assign mem_rdata_i = mem[mem_req_o.addr[5:2]];

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic [31:0] ref_alu(fu_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (op)
            fu_pkg::op_add:  ref_alu = a + b;
            fu_pkg::op_sub:  ref_alu = a + ~b + 32'd1;
            fu_pkg::op_slt:  ref_alu = (sa < $signed(b)) ? 32'd1 : 32'd0;
            fu_pkg::op_sltu: ref_alu = (a < b) ? 32'd1 : 32'd0;
            fu_pkg::op_and:  ref_alu = a & b;
            fu_pkg::op_nor:  ref_alu = ~a & ~b;
            fu_pkg::op_or:   ref_alu = a | b;
            fu_pkg::op_xor:  ref_alu = a ^ b;
            fu_pkg::op_sll:  ref_alu = a << b[4:0];
            fu_pkg::op_srl:  ref_alu = a >> b[4:0];
            fu_pkg::op_sra:  ref_alu = sa >>> b[4:0];
            fu_pkg::op_lui:  ref_alu = b << 12;
            fu_pkg::op_mul:  ref_alu = a * b;
            fu_pkg::op_eq:   ref_alu = (a == b) ? 32'd1 : 32'd0;
            fu_pkg::op_ne:   ref_alu = (a == b) ? 32'd0 : 32'd1;
            default:         ref_alu = 32'd0;
        endcase
    endfunction

    // ======================================================================
    // random instruction source
    // ======================================================================
    task automatic make_req(output fu_pkg::fu_req_t r);
        logic [31:0] rnd;
        logic [31:0] kind;
        r            = '0;
        rnd          = rand32() % 15;
        r.op         = fu_pkg::alu_op_e'(rnd[3:0]);
        r.src1       = rand32();
        r.src2       = rand32();
        r.store_data = rand32();
        r.pc         = rand32() & 32'hffff_fffc;
        r.br_offset  = rand32() & 32'h0000_0ffc;
        rnd          = rand32();
        r.dest       = rnd[4:0];
        r.pred_taken = rnd[5];
        r.gr_we      = 1'b1;
        if (rnd[8:6] == 3'd0) begin
            r.src2 = r.src1;
        end
        kind = rand32() % 8;
        if (kind < 2) begin
            // access inside a small window at MEM_BASE
            r.op     = fu_pkg::op_add;
            r.src1   = MEM_BASE;
            r.src2   = rand32() % 64;
            rnd      = rand32() % 3;
            r.mem_op = fu_pkg::mem_op_e'(rnd[1:0] + 2'd1);
            if (r.mem_op != fu_pkg::mem_store_byte) begin
                r.src2 = r.src2 & 32'hffff_fffc;
            end
            if (r.mem_op != fu_pkg::mem_load_word) begin
                rnd     = rand32();
                r.gr_we = rnd[2];
            end
        end else if (kind < 4) begin
            rnd       = rand32() % 4;
            r.br_kind = fu_pkg::br_kind_e'(rnd[2:0] + 3'd1);
            if (r.br_kind == fu_pkg::br_cond) begin
                rnd  = rand32();
                r.op = rnd[4] ? fu_pkg::op_eq : fu_pkg::op_ne;
            end
        end
    endtask

    // ======================================================================
    // reference model for each accepted instruction
    // ======================================================================
    task automatic model_accept(input fu_pkg::fu_req_t r);
        logic        taken;
        logic [31:0] target;
        logic [31:0] addr;
        logic [1:0]  lane;
        fu_pkg::wb_t exp;
        taken  = 1'b0;
        target = r.pc + r.br_offset;
        addr   = r.src1 + r.src2;
        lane   = addr[1:0];
        case (r.br_kind)
            fu_pkg::br_b, fu_pkg::br_bl: taken = 1'b1;
            fu_pkg::br_jirl: begin
                taken  = 1'b1;
                target = r.src1 + r.br_offset;
            end
            fu_pkg::br_cond: begin
                taken = (r.op == fu_pkg::op_eq) ? (r.src1 == r.src2) : (r.src1 != r.src2);
            end
            default: taken = 1'b0;
        endcase
        if (taken != r.pred_taken) begin
            redirect_q.push_back(taken ? target : r.pc + 32'd4);
        end
        if (r.mem_op == fu_pkg::mem_store_word) begin
            shadow[addr[5:2]] = r.store_data;
        end else if (r.mem_op == fu_pkg::mem_store_byte) begin
            shadow[addr[5:2]][8*int'(lane) +: 8] = r.store_data[7:0];
        end else if (r.gr_we) begin
            exp.valid = 1'b1;
            exp.dest  = r.dest;
            if (r.br_kind == fu_pkg::br_bl || r.br_kind == fu_pkg::br_jirl) begin
                exp.data = r.pc + 32'd4;
            end else if (r.mem_op == fu_pkg::mem_load_word) begin
                exp.data = shadow[addr[5:2]];
            end else begin
                exp.data = ref_alu(r.op, r.src1, r.src2);
            end
            wb_q.push_back(exp);
        end
    endtask

    task automatic check_outputs();
        fu_pkg::wb_t exp;
        logic [31:0] tgt;
        if (wb_o.valid) begin
            wb_seen++;
            if (wb_q.size() == 0) begin
                $display("writeback at %0t with no instruction expecting one", $time);
                errors++;
            end else begin
                exp = wb_q.pop_front();
                if (wb_o.dest != exp.dest) begin
                    $display("Error at %0t: wb_o.dest got %0d expected %0d",
                             $time, wb_o.dest, exp.dest);
                    errors++;
                end
                if (wb_o.data != exp.data) begin
                    $display("Error at %0t: wb_o.data got %h expected %h",
                             $time, wb_o.data, exp.data);
                    errors++;
                end
            end
        end
        if (redirect_o.mispredict) begin
            if (redirect_q.size() == 0) begin
                $display("redirect at %0t where no mispredict was expected", $time);
                errors++;
            end else begin
                tgt = redirect_q.pop_front();
                if (redirect_o.target != tgt) begin
                    $display("Error at %0t: redirect_o.target got %h expected %h",
                             $time, redirect_o.target, tgt);
                    errors++;
                end
            end
        end
        // an access in progress must hold the issue side
        if (mem_req_o.ce && !mem_ready_o && ready_o) begin
            $display("ready_o high at %0t while a memory access is waiting", $time);
            errors++;
        end
    endtask

    // ======================================================================
    // stimulus, memory model and per-cycle checks
    // ======================================================================
    always @(posedge clk) begin
        if (!rst) begin
            check_outputs();
            if (mem_ready_o && !mem_req_o.we_n) begin
                stores_done++;
                for (int i = 0; i < 4; i++) begin
                    if (!mem_req_o.sel_n[i]) begin
                        mem[mem_req_o.addr[5:2]][8*i +: 8] <= mem_req_o.wdata[8*i +: 8];
                    end
                end
            end
            if (valid_i && ready_o) begin
                model_accept(req_i);
                accepted++;
            end
            if (!valid_i || ready_o) begin
                if (accepted < NUM_INSNS && (rand32() % 4) != 0) begin
                    make_req(next_req);
                    valid_i <= 1'b1;
                    req_i   <= next_req;
                end else begin
                    valid_i <= 1'b0;
                end
            end
        end
    end

    task automatic end_test(input string name, input int errors_before);
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: pass", name);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, run still busy after %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int mark;
        clk     = 1'b0;
        rst     = 1'b1;
        valid_i = 1'b0;
        req_i   = '0;
        // fill pattern from the byte address of each word
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = {MEM_BASE[15:0] + 16'(4 * i), ~(MEM_BASE[15:0] + 16'(4 * i))};
            shadow[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        #1;
        mark = errors;
        if (!ready_o || wb_o.valid || redirect_o.mispredict || mem_req_o.ce || mem_ready_o) begin
            $display("outputs not at their reset values after reset");
            errors++;
        end
        end_test("reset", mark);

        mark = errors;
        while (accepted < NUM_INSNS || wb_seen + stores_done < accepted) begin
            @(posedge clk);
        end
        @(posedge clk);
        if (wb_q.size() != 0 || redirect_q.size() != 0) begin
            $display("%0d writebacks and %0d redirects never arrived",
                     wb_q.size(), redirect_q.size());
            errors++;
        end
        end_test("random stream", mark);

        mark = errors;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (mem[i] != shadow[i]) begin
                $display("Error at %0t: mem[%0d] got %h expected %h",
                         $time, i, mem[i], shadow[i]);
                errors++;
            end
        end
        end_test("memory contents", mark);

        mark = errors;
        if (wb_seen + stores_done != accepted) begin
            $display("%0d writebacks and %0d stores for %0d accepted instructions",
                     wb_seen, stores_done, accepted);
            errors++;
        end
        end_test("instruction count", mark);

        $display("tests failed: %0d of 4, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
design/fu_pkg.sv
design/fu_alu.sv
design/fu_branch_unit.sv
design/fu_issue_stage.sv
design/fu_ex_stage.sv
design/fu_mem_stage.sv
design/fu_top.sv
sim/fu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, pass is decided from the log
rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module fu_tb -o fu_sim > build.log 2>&1 \
    && ./obj_dir/fu_sim > sim.log 2>&1 \
    || { echo "build or run failed"; cat build.log; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
